// File: list.f
+incdir+src
src/csr_pkg.sv
src/csr_access_ctrl.sv
src/csr_trap_ctrl.sv
src/csr_machine_regs.sv
src/csr_unit.sv
tb/tb_csr_unit.sv

// File: run.sh
#!/bin/sh
# Compile and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_csr_unit -f list.f -o sim_csr_unit
if [ $? -ne 0 ]; then
    echo "Verilator compilation failed"
    exit 1
fi

./obj_dir/sim_csr_unit > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$log"; then
    exit 0
fi
exit 1

// File: src/csr_access_ctrl.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_access_ctrl
    import csr_pkg::*;
(
    input  logic                   csr_valid,
    input  csr_cmd_e               csr_cmd,
    input  logic [`CSR_ADDR_W-1:0] csr_addr,
    input  logic [`CSR_XLEN-1:0]   csr_operand,
    input  priv_mode_e             mode,
    input  logic [`CSR_XLEN-1:0]   rd_value,
    output logic                   rd_en,
    output logic                   wr_en,
    output logic [`CSR_XLEN-1:0]   wr_data
);

    logic is_rmw;
    logic read_ok;
    logic write_ok;

    // Only W, S and C touch the addressed CSR
    assign is_rmw = (csr_cmd == CMD_W) || (csr_cmd == CMD_S) || (csr_cmd == CMD_C);

    // Bits 9:8 give the lowest mode allowed to access
    assign read_ok = (csr_addr[9:8] <= mode);

    // Bits 11:10 both set means read-only space
    assign write_ok = read_ok && (csr_addr[11:10] != 2'b11);

    assign rd_en = csr_valid && is_rmw && read_ok;
    assign wr_en = csr_valid && is_rmw && write_ok;

    // Read-modify-write data from the pre-write value
    always_comb begin
        case (csr_cmd)
            CMD_W: begin
                wr_data = csr_operand;
            end
            CMD_S: begin
                wr_data = rd_value | csr_operand;
            end
            CMD_C: begin
                wr_data = rd_value & ~csr_operand;
            end
            default: begin
                wr_data = '0;
            end
        endcase
    end

    // A write without read access would bypass the privilege check
    always_comb begin
        assert (!wr_en || rd_en)
            else $error("csr_access_ctrl: write enabled without read access");
    end

endmodule

// File: src/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Datapath widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12
`define CSR_CNT_W           64

// Machine trap setup
`define CSR_A_MSTATUS       12'h300
`define CSR_A_MISA          12'h301
`define CSR_A_MIE           12'h304
`define CSR_A_MTVEC         12'h305

// Machine trap handling
`define CSR_A_MSCRATCH      12'h340
`define CSR_A_MEPC          12'h341
`define CSR_A_MCAUSE        12'h342
`define CSR_A_MIP           12'h344

// User counter views, read-only from any mode
`define CSR_A_CYCLE         12'hc00
`define CSR_A_TIME          12'hc01
`define CSR_A_CYCLEH        12'hc80
`define CSR_A_TIMEH         12'hc81

// MXL=1 (RV32), extensions A, I and M
`define CSR_MISA_VALUE      32'h4000_1101

// mcause encodings, top bit marks an interrupt
`define CSR_CAUSE_ECALL_U   32'd8
`define CSR_CAUSE_ECALL_M   32'd11
`define CSR_CAUSE_MTI       32'h8000_0007

// Timer bit in mie and mip
`define CSR_MTI_BIT         7

// mtvec MODE field value for vectored dispatch
`define CSR_MTVEC_VECTORED  2'b01

`endif

// File: src/csr_machine_regs.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_machine_regs
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   csr_valid,
    input  logic [`CSR_ADDR_W-1:0] csr_addr,
    input  logic                   rd_en,
    input  logic                   wr_en,
    input  logic [`CSR_XLEN-1:0]   wr_data,
    input  priv_mode_e             mode,
    input  logic                   mtip,
    input  logic                   trap_take,
    input  logic                   mret_take,
    input  logic [`CSR_XLEN-1:0]   trap_cause,
    input  logic [`CSR_XLEN-1:0]   trap_epc,
    input  logic [`CSR_CNT_W-1:0]  cycle,
    input  logic [`CSR_CNT_W-1:0]  mtime,
    output logic [`CSR_XLEN-1:0]   rd_value,
    output logic [`CSR_XLEN-1:0]   mtvec,
    output logic [`CSR_XLEN-1:0]   mepc,
    output mstatus_u               mstatus,
    output logic                   mie_mtie,
    output logic [`CSR_XLEN-1:0]   csr_rdata,
    output logic                   csr_done
);

    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mie_word;
    logic [`CSR_XLEN-1:0] mip_word;
    mstatus_u             mstatus_wr;
    mstatus_u             mstatus_legal;

    // mie and mip expose only the timer bit
    always_comb begin
        mie_word = '0;
        mip_word = '0;
        mie_word[`CSR_MTI_BIT] = mie_mtie;
        mip_word[`CSR_MTI_BIT] = mtip;
    end

    // Keep live mstatus fields, MPP limited to U or M
    always_comb begin
        mstatus_wr.raw    = wr_data;
        mstatus_legal.raw = '0;
        mstatus_legal.f.mie  = mstatus_wr.f.mie;
        mstatus_legal.f.mpie = mstatus_wr.f.mpie;
        mstatus_legal.f.mpp  = (mstatus_wr.f.mpp == MODE_M) ? MODE_M : MODE_U;
    end

    // Read mux, unknown addresses read as zero
    always_comb begin
        case (csr_addr)
            `CSR_A_MSTATUS:  rd_value = mstatus.raw;
            `CSR_A_MISA:     rd_value = `CSR_MISA_VALUE;
            `CSR_A_MIE:      rd_value = mie_word;
            `CSR_A_MTVEC:    rd_value = mtvec;
            `CSR_A_MSCRATCH: rd_value = mscratch;
            `CSR_A_MEPC:     rd_value = mepc;
            `CSR_A_MCAUSE:   rd_value = mcause;
            `CSR_A_MIP:      rd_value = mip_word;
            `CSR_A_CYCLE:    rd_value = cycle[`CSR_XLEN-1:0];
            `CSR_A_TIME:     rd_value = mtime[`CSR_XLEN-1:0];
            `CSR_A_CYCLEH:   rd_value = cycle[`CSR_CNT_W-1:`CSR_XLEN];
            `CSR_A_TIMEH:    rd_value = mtime[`CSR_CNT_W-1:`CSR_XLEN];
            default:         rd_value = '0;
        endcase
    end

    // Storage; trap entry and return win over a CSR write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus.raw <= '0;
            mie_mtie    <= 1'b0;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause      <= '0;
        end else if (trap_take) begin
            mcause         <= trap_cause;
            mepc           <= trap_epc;
            // Stack interrupt enable and previous mode
            mstatus.f.mpp  <= mode;
            mstatus.f.mpie <= mstatus.f.mie;
            mstatus.f.mie  <= 1'b0;
        end else if (mret_take) begin
            // Unstack, lowest mode left in MPP
            mstatus.f.mie  <= mstatus.f.mpie;
            mstatus.f.mpie <= 1'b1;
            mstatus.f.mpp  <= MODE_U;
        end else if (wr_en) begin
            case (csr_addr)
                `CSR_A_MSTATUS: begin
                    mstatus <= mstatus_legal;
                end
                `CSR_A_MIE: begin
                    mie_mtie <= wr_data[`CSR_MTI_BIT];
                end
                `CSR_A_MTVEC: begin
                    // Only direct and vectored modes
                    mtvec <= {wr_data[`CSR_XLEN-1:2], 1'b0, wr_data[0]};
                end
                `CSR_A_MSCRATCH: begin
                    mscratch <= wr_data;
                end
                `CSR_A_MEPC: begin
                    mepc <= {wr_data[`CSR_XLEN-1:2], 2'b00};
                end
                `CSR_A_MCAUSE: begin
                    mcause <= wr_data;
                end
                // misa, mip and counters ignore writes
                default: begin
                end
            endcase
        end
    end

    // Old value out one cycle after acceptance
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_done  <= 1'b0;
            csr_rdata <= '0;
        end else begin
            csr_done  <= csr_valid;
            csr_rdata <= rd_en ? rd_value : '0;
        end
    end

    // Done only follows an accepted request
    assert property (@(posedge clk) disable iff (!arst_n) csr_done |-> $past(csr_valid))
        else $error("csr_machine_regs: done without a request");

endmodule

// File: src/csr_pkg.sv
`include "csr_cfg.svh"

package csr_pkg;

    // Request kind from execute stage
    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,
        CMD_S     = 3'd2,
        CMD_C     = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_e;

    // Only U and M, encoded as in the privileged spec
    typedef enum logic [1:0] {
        MODE_U = 2'b00,
        MODE_M = 2'b11
    } priv_mode_e;

    // mstatus layout, only MPP, MPIE and MIE are live
    typedef struct packed {
        logic [18:0] rsvd_hi;
        priv_mode_e  mpp;
        logic [2:0]  rsvd_mid;
        logic        mpie;
        logic [2:0]  rsvd_lo;
        logic        mie;
        logic [2:0]  rsvd_bot;
    } mstatus_fields_t;

    // CSR commands see the raw word, trap logic sees fields
    typedef union packed {
        logic [`CSR_XLEN-1:0] raw;
        mstatus_fields_t      f;
    } mstatus_u;

endpackage

// File: src/csr_trap_ctrl.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_trap_ctrl
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  csr_valid,
    input  csr_cmd_e              csr_cmd,
    input  logic [`CSR_XLEN-1:0]  csr_pc,
    input  logic [`CSR_CNT_W-1:0] mtime,
    input  logic [`CSR_CNT_W-1:0] mtimecmp,
    input  logic [`CSR_XLEN-1:0]  mtvec,
    input  logic [`CSR_XLEN-1:0]  mepc,
    input  mstatus_u              mstatus,
    input  logic                  mie_mtie,
    output priv_mode_e            mode,
    output logic                  mtip,
    output logic                  trap_take,
    output logic                  mret_take,
    output logic [`CSR_XLEN-1:0]  trap_cause,
    output logic [`CSR_XLEN-1:0]  trap_epc,
    output logic                  csr_trap,
    output logic [`CSR_XLEN-1:0]  csr_trap_vector
);

    logic                 irq_take;
    logic                 ecall_take;
    logic [`CSR_XLEN-1:0] mtvec_base;
    logic [`CSR_XLEN-1:0] vector_next;

    // Timer pending, one cycle behind the compare
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtip <= 1'b0;
        end else begin
            mtip <= (mtime >= mtimecmp);
        end
    end

    // Interrupts only on plain instructions
    assign irq_take = csr_valid && (csr_cmd == CMD_NONE) && mtip
                      && mstatus.f.mie && mie_mtie;
    assign ecall_take = csr_valid && (csr_cmd == CMD_ECALL);

    assign trap_take = irq_take || ecall_take;
    assign mret_take = csr_valid && (csr_cmd == CMD_MRET);

    // Cause depends on source and on the mode we trap from
    always_comb begin
        if (irq_take) begin
            trap_cause = `CSR_CAUSE_MTI;
        end else if (mode == MODE_U) begin
            trap_cause = `CSR_CAUSE_ECALL_U;
        end else begin
            trap_cause = `CSR_CAUSE_ECALL_M;
        end
    end

    // Saved pc is word aligned
    assign trap_epc = {csr_pc[`CSR_XLEN-1:2], 2'b00};

    assign mtvec_base = {mtvec[`CSR_XLEN-1:2], 2'b00};

    // Target address
    always_comb begin
        if (mret_take) begin
            vector_next = mepc;
        end else if (irq_take && (mtvec[1:0] == `CSR_MTVEC_VECTORED)) begin
            // Vectored: base + 4 * code, interrupt bit dropped
            vector_next = mtvec_base + {trap_cause[`CSR_XLEN-3:0], 2'b00};
        end else begin
            // Direct mode, and every exception
            vector_next = mtvec_base;
        end
    end

    // Privilege mode
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode <= MODE_M;
        end else if (trap_take) begin
            mode <= MODE_M;
        end else if (mret_take) begin
            // MPP is kept legal by the register file
            mode <= mstatus.f.mpp;
        end
    end

    // Registered trap outputs; vector holds between traps
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_trap        <= 1'b0;
            csr_trap_vector <= '0;
        end else begin
            csr_trap <= trap_take || mret_take;
            if (trap_take || mret_take) begin
                csr_trap_vector <= vector_next;
            end
        end
    end

    // Trap entry and return are mutually exclusive
    assert property (@(posedge clk) disable iff (!arst_n) !(trap_take && mret_take))
        else $error("csr_trap_ctrl: trap and mret in the same request");

    // No S-mode or reserved encoding ever reached
    assert property (@(posedge clk) disable iff (!arst_n)
        (mode == MODE_U) || (mode == MODE_M))
        else $error("csr_trap_ctrl: illegal privilege mode");

endmodule

// File: src/csr_unit.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_unit
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   csr_valid,
    input  csr_cmd_e               csr_cmd,
    input  logic [`CSR_ADDR_W-1:0] csr_addr,
    input  logic [`CSR_XLEN-1:0]   csr_operand,
    input  logic [`CSR_XLEN-1:0]   csr_pc,
    input  logic [`CSR_CNT_W-1:0]  cycle,
    input  logic [`CSR_CNT_W-1:0]  mtime,
    input  logic [`CSR_CNT_W-1:0]  mtimecmp,
    output logic                   csr_done,
    output logic [`CSR_XLEN-1:0]   csr_rdata,
    output logic                   csr_trap,
    output logic [`CSR_XLEN-1:0]   csr_trap_vector
);

    // Access control to register file
    logic                 rd_en;
    logic                 wr_en;
    logic [`CSR_XLEN-1:0] wr_data;
    logic [`CSR_XLEN-1:0] rd_value;

    // Trap control and register file exchange
    priv_mode_e           mode;
    logic                 mtip;
    logic                 trap_take;
    logic                 mret_take;
    logic [`CSR_XLEN-1:0] trap_cause;
    logic [`CSR_XLEN-1:0] trap_epc;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mepc;
    mstatus_u             mstatus;
    logic                 mie_mtie;

    csr_access_ctrl u_access_ctrl (
        .csr_valid   (csr_valid),
        .csr_cmd     (csr_cmd),
        .csr_addr    (csr_addr),
        .csr_operand (csr_operand),
        .mode        (mode),
        .rd_value    (rd_value),
        .rd_en       (rd_en),
        .wr_en       (wr_en),
        .wr_data     (wr_data)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .csr_valid       (csr_valid),
        .csr_cmd         (csr_cmd),
        .csr_pc          (csr_pc),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .mtvec           (mtvec),
        .mepc            (mepc),
        .mstatus         (mstatus),
        .mie_mtie        (mie_mtie),
        .mode            (mode),
        .mtip            (mtip),
        .trap_take       (trap_take),
        .mret_take       (mret_take),
        .trap_cause      (trap_cause),
        .trap_epc        (trap_epc),
        .csr_trap        (csr_trap),
        .csr_trap_vector (csr_trap_vector)
    );

    csr_machine_regs u_machine_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .csr_valid  (csr_valid),
        .csr_addr   (csr_addr),
        .rd_en      (rd_en),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .mode       (mode),
        .mtip       (mtip),
        .trap_take  (trap_take),
        .mret_take  (mret_take),
        .trap_cause (trap_cause),
        .trap_epc   (trap_epc),
        .cycle      (cycle),
        .mtime      (mtime),
        .rd_value   (rd_value),
        .mtvec      (mtvec),
        .mepc       (mepc),
        .mstatus    (mstatus),
        .mie_mtie   (mie_mtie),
        .csr_rdata  (csr_rdata),
        .csr_done   (csr_done)
    );

endmodule

// File: tb/csr_stim.txt
# name cmd addr operand pc mtime mtimecmp cycle exp_rdata exp_trap exp_vector (all hex)
# cmd 0 none 1 w 2 s 3 c 4 ecall 5 mret; exp_vector checked only when exp_trap is 1
w_mscratch      1 340 a5a50f0f 0 0 ffffffffffffffff 0 00000000 0 0
s_mscratch      2 340 0000f0f0 0 0 ffffffffffffffff 0 a5a50f0f 0 0
c_mscratch      3 340 a5a50000 0 0 ffffffffffffffff 0 a5a5ffff 0 0
rd_mscratch     2 340 00000000 0 0 ffffffffffffffff 0 0000ffff 0 0
rd_misa         2 301 00000000 0 0 ffffffffffffffff 0 40001101 0 0
rd_cycle        2 c00 00000000 0 0 ffffffffffffffff 0123456789abcdef 89abcdef 0 0
rd_cycleh       2 c80 00000000 0 0 ffffffffffffffff 0123456789abcdef 01234567 0 0
rd_timeh        2 c81 00000000 0 0000000200000001 ffffffffffffffff 0 00000002 0 0
rd_unknown      2 3c0 00000000 0 0 ffffffffffffffff 0 00000000 0 0
w_cycle         1 c00 ffffffff 0 0 ffffffffffffffff 0123456789abcdef 89abcdef 0 0
rd_cycle_after  2 c00 00000000 0 0 ffffffffffffffff 0123456789abcdef 89abcdef 0 0
w_mtvec_direct  1 305 00000100 0 0 ffffffffffffffff 0 00000000 0 0
ecall_m         4 000 00000000 00001236 0 ffffffffffffffff 0 00000000 1 00000100
rd_mcause_m     2 342 00000000 0 0 ffffffffffffffff 0 0000000b 0 0
rd_mepc_m       2 341 00000000 0 0 ffffffffffffffff 0 00001234 0 0
w_mstatus_mpp_u 1 300 00000000 0 0 ffffffffffffffff 0 00001800 0 0
mret_to_u       5 000 00000000 0 0 ffffffffffffffff 0 00000000 1 00001234
rd_mscratch_u   2 340 00000000 0 0 ffffffffffffffff 0 00000000 0 0
w_mscratch_u    1 340 deadbeef 0 0 ffffffffffffffff 0 00000000 0 0
ecall_u         4 000 00000000 00002002 0 ffffffffffffffff 0 00000000 1 00000100
rd_mcause_u     2 342 00000000 0 0 ffffffffffffffff 0 00000008 0 0
rd_mscratch_m   2 340 00000000 0 0 ffffffffffffffff 0 0000ffff 0 0
w_mtvec_vec     1 305 00000201 0 0 ffffffffffffffff 0 00000100 0 0
w_mie_mtie      1 304 00000080 0 100 80 0 00000000 0 0
w_mstatus_mie   1 300 00000008 0 100 80 0 00000000 0 0
irq_timer       0 000 00000000 00003000 100 80 0 00000000 1 0000021c
rd_mcause_irq   2 342 00000000 0 100 80 0 80000007 0 0
rd_mstatus_irq  2 300 00000000 0 100 80 0 00001880 0 0
rd_mip          2 344 00000000 0 100 80 0 00000080 0 0

// File: tb/tb_csr_unit.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module tb_csr_unit
    import csr_pkg::*;
();

    logic                   clk;
    logic                   arst_n;
    logic                   csr_valid;
    csr_cmd_e               csr_cmd;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`CSR_XLEN-1:0]   csr_operand;
    logic [`CSR_XLEN-1:0]   csr_pc;
    logic [`CSR_CNT_W-1:0]  cycle;
    logic [`CSR_CNT_W-1:0]  mtime;
    logic [`CSR_CNT_W-1:0]  mtimecmp;
    logic                   csr_done;
    logic [`CSR_XLEN-1:0]   csr_rdata;
    logic                   csr_trap;
    logic [`CSR_XLEN-1:0]   csr_trap_vector;

    // One entry per stimulus line
    string                  name_q[$];
    logic [2:0]             cmd_q[$];
    logic [`CSR_ADDR_W-1:0] addr_q[$];
    logic [`CSR_XLEN-1:0]   operand_q[$];
    logic [`CSR_XLEN-1:0]   pc_q[$];
    logic [`CSR_CNT_W-1:0]  mtime_q[$];
    logic [`CSR_CNT_W-1:0]  mtimecmp_q[$];
    logic [`CSR_CNT_W-1:0]  cycle_q[$];
    logic [`CSR_XLEN-1:0]   exp_rdata_q[$];
    logic                   exp_trap_q[$];
    logic [`CSR_XLEN-1:0]   exp_vector_q[$];

    // Parse scratch
    string                  f_name;
    logic [2:0]             f_cmd;
    logic [`CSR_ADDR_W-1:0] f_addr;
    logic [`CSR_XLEN-1:0]   f_operand;
    logic [`CSR_XLEN-1:0]   f_pc;
    logic [`CSR_CNT_W-1:0]  f_mtime;
    logic [`CSR_CNT_W-1:0]  f_mtimecmp;
    logic [`CSR_CNT_W-1:0]  f_cycle;
    logic [`CSR_XLEN-1:0]   f_rdata;
    logic                   f_trap;
    logic [`CSR_XLEN-1:0]   f_vector;

    // Target of the most recent expected trap, zero out of reset
    logic [`CSR_XLEN-1:0]   held_vector;

    integer n_tests;
    integer pass_count;
    integer fail_count;
    integer load_errors;
    integer idx;
    bit     loaded = 1'b0;

    csr_unit u_csr_unit (
        .clk             (clk),
        .arst_n          (arst_n),
        .csr_valid       (csr_valid),
        .csr_cmd         (csr_cmd),
        .csr_addr        (csr_addr),
        .csr_operand     (csr_operand),
        .csr_pc          (csr_pc),
        .cycle           (cycle),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .csr_done        (csr_done),
        .csr_rdata       (csr_rdata),
        .csr_trap        (csr_trap),
        .csr_trap_vector (csr_trap_vector)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // Reads every request of the data file before the run starts
    task automatic load_stimulus();
        integer fd;
        integer nread;
        integer nfields;
        string  line;
        fd = $fopen("tb/csr_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb/csr_stim.txt");
            load_errors = load_errors + 1;
        end else begin
            while (!$feof(fd)) begin
                nread = $fgets(line, fd);
                // Skip blank lines and lines starting with a hash mark
                if (nread > 1 && line.getc(0) != 8'h23) begin
                    nfields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h",
                                      f_name, f_cmd, f_addr, f_operand, f_pc, f_mtime,
                                      f_mtimecmp, f_cycle, f_rdata, f_trap, f_vector);
                    if (nfields == 11) begin
                        name_q.push_back(f_name);
                        cmd_q.push_back(f_cmd);
                        addr_q.push_back(f_addr);
                        operand_q.push_back(f_operand);
                        pc_q.push_back(f_pc);
                        mtime_q.push_back(f_mtime);
                        mtimecmp_q.push_back(f_mtimecmp);
                        cycle_q.push_back(f_cycle);
                        exp_rdata_q.push_back(f_rdata);
                        exp_trap_q.push_back(f_trap);
                        exp_vector_q.push_back(f_vector);
                    end else begin
                        $display("Malformed stimulus line: %s", line);
                        load_errors = load_errors + 1;
                    end
                end
            end
            $fclose(fd);
        end
        n_tests = name_q.size();
    endtask

    // Drives one request, called on a falling edge
    task automatic apply_request(input integer i);
        csr_valid   = 1'b1;
        csr_cmd     = csr_cmd_e'(cmd_q[i]);
        csr_addr    = addr_q[i];
        csr_operand = operand_q[i];
        csr_pc      = pc_q[i];
        mtime       = mtime_q[i];
        mtimecmp    = mtimecmp_q[i];
        cycle       = cycle_q[i];
    endtask

    // Outputs of the request accepted at the last rising edge
    task automatic check_response(input integer i);
        integer errs;
        errs = 0;
        if (csr_done !== 1'b1) begin
            $display("[FAIL] %s csr_done expected 1 actual %b", name_q[i], csr_done);
            errs = errs + 1;
        end
        if (csr_rdata !== exp_rdata_q[i]) begin
            $display("[FAIL] %s csr_rdata expected %h actual %h",
                     name_q[i], exp_rdata_q[i], csr_rdata);
            errs = errs + 1;
        end
        if (csr_trap !== exp_trap_q[i]) begin
            $display("[FAIL] %s csr_trap expected %b actual %b",
                     name_q[i], exp_trap_q[i], csr_trap);
            errs = errs + 1;
        end
        // New target on a trap, last target held otherwise
        if (exp_trap_q[i]) begin
            if (csr_trap_vector !== exp_vector_q[i]) begin
                $display("[FAIL] %s csr_trap_vector expected %h actual %h",
                         name_q[i], exp_vector_q[i], csr_trap_vector);
                errs = errs + 1;
            end
            held_vector = exp_vector_q[i];
        end else if (csr_trap_vector !== held_vector) begin
            $display("[FAIL] %s csr_trap_vector expected %h actual %h",
                     name_q[i], held_vector, csr_trap_vector);
            errs = errs + 1;
        end
        if (errs == 0) begin
            pass_count = pass_count + 1;
            $display("[PASS] %s", name_q[i]);
        end else begin
            fail_count = fail_count + 1;
        end
    endtask

    // Outputs when no request was accepted at the last rising edge
    task automatic check_quiet(input string tag);
        integer errs;
        errs = 0;
        if (csr_done !== 1'b0) begin
            $display("[FAIL] %s csr_done expected 0 actual %b", tag, csr_done);
            errs = errs + 1;
        end
        if (csr_trap !== 1'b0) begin
            $display("[FAIL] %s csr_trap expected 0 actual %b", tag, csr_trap);
            errs = errs + 1;
        end
        if (csr_rdata !== '0) begin
            $display("[FAIL] %s csr_rdata expected %h actual %h", tag, 32'h0, csr_rdata);
            errs = errs + 1;
        end
        if (csr_trap_vector !== held_vector) begin
            $display("[FAIL] %s csr_trap_vector expected %h actual %h",
                     tag, held_vector, csr_trap_vector);
            errs = errs + 1;
        end
        if (errs == 0) begin
            pass_count = pass_count + 1;
            $display("[PASS] %s", tag);
        end else begin
            fail_count = fail_count + 1;
        end
    endtask

    initial begin : main
        clk         = 1'b0;
        arst_n      = 1'b0;
        csr_valid   = 1'b0;
        csr_cmd     = CMD_NONE;
        csr_addr    = '0;
        csr_operand = '0;
        csr_pc      = '0;
        cycle       = '0;
        mtime       = '0;
        // Compare value at maximum keeps the timer quiet
        mtimecmp    = '1;
        held_vector = '0;
        n_tests     = 0;
        pass_count  = 0;
        fail_count  = 0;
        load_errors = 0;
        load_stimulus();
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_quiet("reset_state");
        // Back-to-back requests, one per cycle
        for (idx = 0; idx < n_tests; idx = idx + 1) begin
            apply_request(idx);
            @(negedge clk);
            check_response(idx);
        end
        csr_valid = 1'b0;
        csr_cmd   = CMD_NONE;
        @(negedge clk);
        // Done drops once requests stop
        check_quiet("idle");
        $display("Tests passed: %0d, failed: %0d, stimulus errors: %0d",
                 pass_count, fail_count, load_errors);
        if (fail_count == 0 && load_errors == 0 && n_tests > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Budget of four periods per line plus margin for reset
    initial begin : watchdog
        wait (loaded);
        #((n_tests + 40) * 400);
        $display("Timeout: the run did not reach its final report");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
